// File: hw/aluPkg.sv
`default_nettype none

package aluPkg;

  // data words and register offsets
  typedef logic [31:0] aluWord;
  typedef logic [4:0]  axiAddr;
  typedef logic [1:0]  axiResp;

  // command encoding as seen in the command register
  typedef enum logic [2:0] {
    CmdAdd  = 3'd0,
    CmdSub  = 3'd1,
    CmdXor  = 3'd2,
    CmdSlt  = 3'd3,
    CmdAnd  = 3'd4,
    CmdNand = 3'd5,
    CmdNor  = 3'd6,
    CmdOr   = 3'd7
  } aluCmd;

  typedef enum logic [1:0] {SelAdd, SelXor, SelAnd, SelOr} resultSel;

  typedef struct packed {
    resultSel sel;
    logic     invertA;
    logic     invertB;
    logic     carryIn;     // 1 turns the adder into a subtractor with invertB
    logic     enableFlags; // carry and overflow only count for arithmetic
    logic     isSlt;
  } aluCtrl;

  typedef struct packed {
    logic zero;     // bit 2 in the flags register
    logic overflow;
    logic carry;
  } aluFlags;

  typedef struct packed {
    logic   awvalid;
    axiAddr awaddr;
    logic   wvalid;
    aluWord wdata;
    logic   bready;
    logic   arvalid;
    axiAddr araddr;
    logic   rready;
  } axiLiteReq;

  typedef struct packed {
    logic   awready;
    logic   wready;
    logic   bvalid;
    axiResp bresp;
    logic   arready;
    logic   rvalid;
    aluWord rdata;
    axiResp rresp;
  } axiLiteRsp;

  localparam axiAddr AddrOpA     = 5'h00;
  localparam axiAddr AddrOpB     = 5'h04;
  localparam axiAddr AddrCmd     = 5'h08;
  localparam axiAddr AddrResult  = 5'h0C;
  localparam axiAddr AddrFlags   = 5'h10;

  localparam axiResp RespOkay    = 2'd0;
  localparam axiResp RespSlvErr  = 2'd2;

endpackage

`default_nettype wire

// File: hw/aluControlDecode.sv
`timescale 1ns/100ps
`default_nettype none

module aluControlDecode (
  input  wire aluPkg::aluCmd cmd,
  output aluPkg::aluCtrl     ctrl
);
  import aluPkg::*;

  // command to datapath control table with an extra flag for SLT
  always_comb begin
    ctrl = '{sel: SelAdd, invertA: 1'b0, invertB: 1'b0, carryIn: 1'b0,
             enableFlags: 1'b1, isSlt: 1'b0};
    case (cmd)
      CmdAdd: ;  // defaults above
      CmdSub: begin
        ctrl.invertB = 1'b1;  // a + ~b + 1
        ctrl.carryIn = 1'b1;
      end
      CmdXor: begin
        ctrl.sel         = SelXor;
        ctrl.enableFlags = 1'b0;
      end
      CmdSlt: begin
        ctrl.invertB = 1'b1;
        ctrl.carryIn = 1'b1;
        ctrl.isSlt   = 1'b1;
      end
      CmdAnd: begin
        ctrl.sel         = SelAnd;
        ctrl.enableFlags = 1'b0;
      end
      CmdNand: begin
        // ~a | ~b
        ctrl.sel         = SelOr;
        ctrl.invertA     = 1'b1;
        ctrl.invertB     = 1'b1;
        ctrl.enableFlags = 1'b0;
      end
      CmdNor: begin
        ctrl.sel         = SelAnd;  // ~a & ~b
        ctrl.invertA     = 1'b1;
        ctrl.invertB     = 1'b1;
        ctrl.enableFlags = 1'b0;
      end
      CmdOr: begin
        ctrl.sel         = SelOr;
        ctrl.enableFlags = 1'b0;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/rippleAdder32.sv
`timescale 1ns/100ps
`default_nettype none

module rippleAdder32 (
  input  wire aluPkg::aluWord a,
  input  wire aluPkg::aluWord b,
  input  wire                 carryIn,
  input  wire                 invertB,
  output aluPkg::aluWord      sum,
  output logic                carryOut,
  output logic                overflow
);

  logic [31:0] bEff;   // b after the optional inversion
  logic [32:0] carry;  // carry[i] enters bit i

  assign bEff     = invertB ? ~b : b;
  assign carry[0] = carryIn;

  for (genvar i = 0; i < 32; i++) begin : genStage
    logic half;  // a xor b for this stage

    assign half         = a[i] ^ bEff[i];
    assign sum[i]       = half ^ carry[i];
    assign carry[i + 1] = (a[i] & bEff[i]) | (half & carry[i]);
  end

  assign carryOut = carry[32];

  // signed overflow when the carries into and out of the sign bit disagree
  assign overflow = carry[31] ^ carry[32];

endmodule

`default_nettype wire

// File: hw/logicUnit32.sv
`timescale 1ns/100ps
`default_nettype none

module logicUnit32 (
  input  wire aluPkg::aluWord a,
  input  wire aluPkg::aluWord b,
  input  wire                 invertA,
  input  wire                 invertB,
  output aluPkg::aluWord      andResult,
  output aluPkg::aluWord      orResult,
  output aluPkg::aluWord      xorResult
);

  logic [31:0] aEff;
  logic [31:0] bEff;

  assign aEff = invertA ? ~a : a;
  assign bEff = invertB ? ~b : b;

  // with both inputs inverted the and path gives NOR, the or path NAND
  assign andResult = aEff & bEff;
  assign orResult  = aEff | bEff;
  assign xorResult = aEff ^ bEff;

endmodule

`default_nettype wire

// File: hw/aluCore.sv
`timescale 1ns/100ps
`default_nettype none

module aluCore (
  input  wire aluPkg::aluWord opA,
  input  wire aluPkg::aluWord opB,
  input  wire aluPkg::aluCmd  cmd,
  output aluPkg::aluWord      result,
  output aluPkg::aluFlags     flags
);
  import aluPkg::*;

  aluCtrl ctrl;
  aluWord addResult;
  aluWord andResult;
  aluWord orResult;
  aluWord xorResult;
  logic   carryOut;
  logic   overflow;

  aluControlDecode i_aluControlDecode (
    .cmd  (cmd),
    .ctrl (ctrl)
  );

  rippleAdder32 i_rippleAdder32 (
    .a        (opA),
    .b        (opB),
    .carryIn  (ctrl.carryIn),
    .invertB  (ctrl.invertB),
    .sum      (addResult),
    .carryOut (carryOut),
    .overflow (overflow)
  );

  logicUnit32 i_logicUnit32 (
    .a         (opA),
    .b         (opB),
    .invertA   (ctrl.invertA),
    .invertB   (ctrl.invertB),
    .andResult (andResult),
    .orResult  (orResult),
    .xorResult (xorResult)
  );

  always_comb begin
    case (ctrl.sel)
      SelAdd:  result = addResult;
      SelXor:  result = xorResult;
      SelAnd:  result = andResult;
      SelOr:   result = orResult;
      default: result = addResult;
    endcase

    // a < b when the sign of a - b is wrong or flipped by overflow
    if (ctrl.isSlt) begin
      result = {31'b0, addResult[31] ^ overflow};
    end
  end

  assign flags.zero     = (result == '0);
  assign flags.carry    = carryOut & ctrl.enableFlags;  // logic ops read 0
  assign flags.overflow = overflow & ctrl.enableFlags;

endmodule

`default_nettype wire

// File: hw/aluAxiRegs.sv
`timescale 1ns/100ps
`default_nettype none

module aluAxiRegs (
  input  wire                    clk,
  input  wire                    reset,
  input  wire aluPkg::axiLiteReq req,
  output aluPkg::axiLiteRsp      rsp,
  output aluPkg::aluWord         opA,
  output aluPkg::aluWord         opB,
  output aluPkg::aluCmd          cmd,
  input  wire aluPkg::aluWord    result,
  input  wire aluPkg::aluFlags   flags
);
  import aluPkg::*;

  typedef enum logic {WrIdle, WrResp} wrStateType;
  typedef enum logic {RdIdle, RdData} rdStateType;

  wrStateType wrState;
  rdStateType rdState;
  logic       live;        // held low during reset and the cycle after it
  logic       wrAccept;    // aw and w handshake in this cycle
  logic       wrMapped;
  logic       arReady;
  logic       rdAccept;
  axiResp     bresp;
  axiResp     rresp;
  aluWord     rdata;
  aluWord     resultQ;
  aluFlags    flagsQ;

  always_ff @(posedge clk) begin
    if (reset) begin
      live <= 1'b0;
    end else begin
      live <= 1'b1;
    end
  end

  // address and data are taken together, never one without the other
  assign wrAccept = live && (wrState == WrIdle) && req.awvalid && req.wvalid;
  assign wrMapped = (req.awaddr == AddrOpA) || (req.awaddr == AddrOpB) ||
                    (req.awaddr == AddrCmd);
  assign arReady  = live && (rdState == RdIdle);
  assign rdAccept = arReady && req.arvalid;

  always_comb begin
    rsp.awready = wrAccept;
    rsp.wready  = wrAccept;
    rsp.bvalid  = (wrState == WrResp);
    rsp.bresp   = bresp;
    rsp.arready = arReady;
    rsp.rvalid  = (rdState == RdData);
    rsp.rdata   = rdata;
    rsp.rresp   = rresp;
  end

  // write channel and the writable registers
  always_ff @(posedge clk) begin
    if (reset) begin
      wrState <= WrIdle;
      opA     <= '0;
      opB     <= '0;
      cmd     <= CmdAdd;
    end else begin
      case (wrState)
        WrIdle:  if (wrAccept) wrState <= WrResp;
        WrResp:  if (req.bready) wrState <= WrIdle;
        default: wrState <= WrIdle;
      endcase

      if (wrAccept) begin
        case (req.awaddr)
          AddrOpA: opA <= req.wdata;
          AddrOpB: opB <= req.wdata;
          AddrCmd: cmd <= aluCmd'(req.wdata[2:0]);  // upper bits dropped
          default: ;  // result, flags and holes are read only
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wrAccept) begin
      bresp <= wrMapped ? RespOkay : RespSlvErr;
    end
  end

  // read channel
  always_ff @(posedge clk) begin
    if (reset) begin
      rdState <= RdIdle;
    end else begin
      case (rdState)
        RdIdle:  if (rdAccept) rdState <= RdData;
        RdData:  if (req.rready) rdState <= RdIdle;
        default: rdState <= RdIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rdAccept) begin
      rresp <= RespOkay;
      case (req.araddr)
        AddrOpA:    rdata <= opA;
        AddrOpB:    rdata <= opB;
        AddrCmd:    rdata <= {29'b0, cmd};
        AddrResult: rdata <= resultQ;
        AddrFlags:  rdata <= {29'b0, flagsQ};
        default: begin
          rdata <= '0;
          rresp <= RespSlvErr;
        end
      endcase
    end
  end

  // core outputs sampled every cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      resultQ <= '0;
      flagsQ  <= '0;
    end else begin
      resultQ <= result;
      flagsQ  <= flags;
    end
  end

endmodule

`default_nettype wire

// File: hw/aluSubsystem.sv
`timescale 1ns/100ps
`default_nettype none

module aluSubsystem (
  input  wire                    clk,
  input  wire                    reset,
  input  wire aluPkg::axiLiteReq req,
  output aluPkg::axiLiteRsp      rsp
);
  import aluPkg::*;

  aluWord  opA;
  aluWord  opB;
  aluCmd   cmd;
  aluWord  result;
  aluFlags flags;

  // register block on the bus side
  aluAxiRegs i_aluAxiRegs (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .rsp    (rsp),
    .opA    (opA),
    .opB    (opB),
    .cmd    (cmd),
    .result (result),
    .flags  (flags)
  );

  // purely combinational datapath
  aluCore i_aluCore (
    .opA    (opA),
    .opB    (opB),
    .cmd    (cmd),
    .result (result),
    .flags  (flags)
  );

endmodule

`default_nettype wire

// File: tb/aluChecker.sv
`timescale 1ns/100ps
`default_nettype none

module aluChecker (
  input wire                    clk,
  input wire                    reset,
  input wire aluPkg::axiLiteReq req,
  input wire aluPkg::axiLiteRsp rsp
);
  import aluPkg::*;

  aluWord expData[$];   // one entry per read still to complete
  axiResp expResp[$];
  string  expName[$];
  int     errorCount = 0;
  logic   readPending = 1'b0;
  logic   heldLast = 1'b0;  // rvalid without rready at the previous edge
  aluWord heldData;
  axiResp heldResp;

  task automatic expectRead(aluWord data, axiResp resp, string name);
    expData.push_back(data);
    expResp.push_back(resp);
    expName.push_back(name);
  endtask

  // values seen here are the ones settled before the edge
  always @(posedge clk) begin
    if (!reset) begin
      if (rsp.rvalid && !readPending) begin
        $display("read data came back with no read outstanding");
        errorCount++;
      end
      if (rsp.rvalid && rsp.arready) begin
        $display("a new read address was accepted while read data was still held");
        errorCount++;
      end
      if (heldLast && (!rsp.rvalid || rsp.rdata !== heldData || rsp.rresp !== heldResp)) begin
        $display("read response was dropped or changed while rready was low");
        errorCount++;
      end
      heldLast = rsp.rvalid && !req.rready;
      heldData = rsp.rdata;
      heldResp = rsp.rresp;

      if (rsp.rvalid && req.rready) begin
        readPending = 1'b0;
        if (expData.size() == 0) begin
          $display("a read completed that the testbench never asked for");
          errorCount++;
        end else begin
          if (rsp.rdata !== expData[0] || rsp.rresp !== expResp[0]) begin
            $display("[ERROR] %s: expected %h resp %0d, actual %h resp %0d",
                     expName[0], expData[0], expResp[0], rsp.rdata, rsp.rresp);
            errorCount++;
          end
          void'(expData.pop_front());
          void'(expResp.pop_front());
          void'(expName.pop_front());
        end
      end

      if (req.arvalid && rsp.arready) readPending = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: tb/aluTb.sv
`timescale 1ns/100ps
`default_nettype none

module aluTb;
  import aluPkg::*;

  typedef enum logic [1:0] {AccessPlain, AccessHold, AccessRegMap} accessPat;

  typedef struct packed {
    aluWord   opA;
    aluWord   opB;
    aluCmd    cmd;
    accessPat access;
  } testRow;

  logic        clk;
  logic        reset;
  axiLiteReq   req;
  axiLiteRsp   rsp;
  testRow      rows[$];
  string       names[$];
  logic [31:0] lfsrState = 32'h5b7d_12ba;
  int          writeErrors = 0;
  int          watchdogCycles = 0;

  aluSubsystem i_aluSubsystem (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .rsp   (rsp)
  );

  aluChecker i_aluChecker (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .rsp   (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] takeBits(int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h8020_0003 : lfsrState >> 1;
      value = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  // returns {result, zero, overflow, carry}
  function automatic logic [34:0] modelAlu(aluWord a, aluWord b, aluCmd cmd);
    logic [32:0] wide;
    aluWord      res;
    logic        ovf;
    wide = '0;
    ovf  = 1'b0;
    case (cmd)
      CmdAdd: begin
        wide = {1'b0, a} + {1'b0, b};
        ovf  = (a[31] == b[31]) && (wide[31] != a[31]);
      end
      CmdSub, CmdSlt: begin
        wide = {1'b0, a} + {1'b0, ~b} + 33'd1;  // carry set means no borrow
        ovf  = (a[31] != b[31]) && (wide[31] != a[31]);
      end
      default: ;  // logic ops leave carry and overflow at 0
    endcase
    case (cmd)
      CmdXor:  res = a ^ b;
      CmdAnd:  res = a & b;
      CmdNand: res = ~(a & b);
      CmdNor:  res = ~(a | b);
      CmdOr:   res = a | b;
      CmdSlt:  res = {31'b0, $signed(a) < $signed(b)};
      default: res = wide[31:0];
    endcase
    return {res, res == 32'b0, ovf, wide[32]};
  endfunction

  task automatic addRow(string name, aluWord a, aluWord b, aluCmd cmd, accessPat access);
    rows.push_back('{opA: a, opB: b, cmd: cmd, access: access});
    names.push_back(name);
  endtask

  task automatic buildTable();
    aluWord a;
    aluWord b;
    aluCmd  cmd;
    addRow("add_zero", 32'h0, 32'h0, CmdAdd, AccessPlain);
    addRow("add_basic", 32'h1234_5678, 32'h0FED_CBA9, CmdAdd, AccessHold);
    addRow("add_ovf", 32'h7FFF_FFFF, 32'h1, CmdAdd, AccessPlain);
    addRow("add_carry", 32'hFFFF_FFFF, 32'h1, CmdAdd, AccessPlain);
    addRow("sub_basic", 32'd100, 32'd58, CmdSub, AccessPlain);
    addRow("sub_borrow", 32'd5, 32'd7, CmdSub, AccessPlain);
    addRow("sub_ovf", 32'h8000_0000, 32'h1, CmdSub, AccessHold);
    addRow("xor_ones", 32'hFFFF_FFFF, 32'h0, CmdXor, AccessPlain);
    addRow("and_ones", 32'hFFFF_FFFF, 32'hFFFF_FFFF, CmdAnd, AccessPlain);
    addRow("nand_ones", 32'hFFFF_FFFF, 32'hFFFF_FFFF, CmdNand, AccessPlain);
    addRow("nor_zero", 32'h0, 32'h0, CmdNor, AccessPlain);
    addRow("or_zero", 32'h0, 32'h0, CmdOr, AccessPlain);
    addRow("slt_min_one", 32'h8000_0000, 32'h1, CmdSlt, AccessPlain);  // difference overflows
    addRow("slt_min_max", 32'h8000_0000, 32'h7FFF_FFFF, CmdSlt, AccessPlain);
    addRow("slt_max_min", 32'h7FFF_FFFF, 32'h8000_0000, CmdSlt, AccessPlain);
    addRow("slt_neg_zero", 32'hFFFF_FFFF, 32'h0, CmdSlt, AccessPlain);
    addRow("slt_equal", 32'd5, 32'd5, CmdSlt, AccessPlain);
    addRow("regmap_sub", 32'hA5A5_0F0F, 32'h0000_1234, CmdSub, AccessRegMap);
    addRow("regmap_nor", 32'h0F0F_F0F0, 32'h3C3C_C3C3, CmdNor, AccessRegMap);
    for (int i = 0; i < 16; i++) begin
      a   = takeBits(32);
      b   = takeBits(32);
      cmd = aluCmd'(takeBits(3));
      addRow($sformatf("rand_%0d", i), a, b, cmd, (i % 3 == 0) ? AccessHold : AccessPlain);
    end
  endtask

  // starts and ends just after a falling edge
  task automatic axiWrite(axiAddr addr, aluWord data, axiResp expResp, string name,
                          int holdCycles);
    axiResp firstResp;
    req.awvalid = 1'b1;
    req.awaddr  = addr;
    req.wvalid  = 1'b1;
    req.wdata   = data;
    req.bready  = (holdCycles == 0);
    @(negedge clk);
    while (!rsp.bvalid) @(negedge clk);
    firstResp = rsp.bresp;
    if (firstResp !== expResp) begin
      $display("[ERROR] %s: expected bresp %0d, actual %0d", name, expResp, firstResp);
      writeErrors++;
    end
    // aw and w stay up during the hold so a second accept would show as awready or wready
    repeat (holdCycles) begin
      @(negedge clk);
      if (!rsp.bvalid || rsp.bresp !== firstResp || rsp.awready || rsp.wready) begin
        $display("write response in %s changed or a second write was taken", name);
        writeErrors++;
      end
    end
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    req.bready  = 1'b1;
    @(negedge clk);
    req.bready  = 1'b0;
  endtask

  task automatic axiRead(axiAddr addr, aluWord expData, axiResp expResp, string name,
                         int holdCycles);
    i_aluChecker.expectRead(expData, expResp, name);
    req.arvalid = 1'b1;
    req.araddr  = addr;
    req.rready  = (holdCycles == 0);
    @(negedge clk);
    while (!rsp.rvalid) @(negedge clk);
    repeat (holdCycles) @(negedge clk);  // checker watches the held data
    req.arvalid = 1'b0;
    req.rready  = 1'b1;
    @(negedge clk);
    req.rready  = 1'b0;
  endtask

  task automatic applyRow(testRow row, string name);
    logic [34:0] expected;
    int          writeHold;
    int          readHold;
    expected  = modelAlu(row.opA, row.opB, row.cmd);
    writeHold = (row.access == AccessHold) ? 1 + int'(takeBits(2)) : 0;
    readHold  = (row.access == AccessHold) ? 1 + int'(takeBits(2)) : 0;
    axiWrite(AddrOpA, row.opA, RespOkay, name, 0);
    axiWrite(AddrOpB, row.opB, RespOkay, name, 0);
    if (row.access == AccessRegMap) begin
      axiWrite(AddrCmd, {29'h0AA5_5A5A, row.cmd}, RespOkay, name, 0);  // junk above bit 2
    end else begin
      axiWrite(AddrCmd, {29'b0, row.cmd}, RespOkay, name, writeHold);
    end
    axiRead(AddrResult, expected[34:3], RespOkay, name, readHold);
    axiRead(AddrFlags, {29'b0, expected[2:0]}, RespOkay, name, 0);
    if (row.access == AccessRegMap) begin
      axiRead(AddrOpA, row.opA, RespOkay, name, 0);
      axiRead(AddrOpB, row.opB, RespOkay, name, 0);
      axiRead(AddrCmd, {29'b0, row.cmd}, RespOkay, name, 0);
      axiWrite(AddrResult, ~expected[34:3], RespSlvErr, name, 0);
      axiWrite(AddrFlags, 32'h7, RespSlvErr, name, 0);
      axiWrite(5'h18, 32'h1, RespSlvErr, name, 0);
      axiRead(AddrResult, expected[34:3], RespOkay, name, 0);
      axiRead(AddrFlags, {29'b0, expected[2:0]}, RespOkay, name, 0);
      axiRead(5'h14, 32'h0, RespSlvErr, name, 0);
    end
  endtask

  initial begin
    req   = '0;
    reset = 1'b1;
    buildTable();
    watchdogCycles = rows.size() * 200 + 10;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // state straight out of reset while the core sees 0 + 0
    axiRead(AddrCmd, {29'b0, CmdAdd}, RespOkay, "reset_cmd", 0);
    axiRead(AddrResult, 32'h0, RespOkay, "reset_result", 0);
    axiRead(AddrFlags, 32'h4, RespOkay, "reset_flags", 0);

    foreach (rows[i]) applyRow(rows[i], names[i]);
    @(negedge clk);

    $display("errors: %0d in write responses, %0d in reads", writeErrors,
             i_aluChecker.errorCount);
    if (writeErrors != 0 || i_aluChecker.errorCount != 0) begin
      $display("RESULT: FAIL");
    end else begin
      $display("RESULT: PASS");
    end
    $finish;
  end

  initial begin
    wait (watchdogCycles > 0);
    repeat (watchdogCycles) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", watchdogCycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
hw/aluPkg.sv
hw/aluControlDecode.sv
hw/rippleAdder32.sv
hw/logicUnit32.sv
hw/aluCore.sv
hw/aluAxiRegs.sv
hw/aluSubsystem.sv
tb/aluChecker.sv
tb/aluTb.sv

// File: Bender.yml
package:
  name: alu_axi_lite

sources:
  - hw/aluPkg.sv
  - hw/aluControlDecode.sv
  - hw/rippleAdder32.sv
  - hw/logicUnit32.sv
  - hw/aluCore.sv
  - hw/aluAxiRegs.sv
  - hw/aluSubsystem.sv
  - target: test
    files:
      - tb/aluChecker.sv
      - tb/aluTb.sv
